//--- verilog/fifo_pkg.sv
package fifo_pkg;

	// default geometry that the top level overrides
	localparam int DEFAULT_DATA_WIDTH = 8;
	localparam int DEFAULT_DEPTH = 8; // power of two

	// flops in each pointer crossing
	localparam int SYNC_STAGES = 2;

	// widest pointer the conversion handles
	localparam int GRAY_MAX_WIDTH = 32;

	// binary to reflected Gray code
	// callers zero-extend and keep the low bits they need
	function automatic logic [GRAY_MAX_WIDTH-1:0] bin_to_gray(
		input logic [GRAY_MAX_WIDTH-1:0] bin
	);
		logic [GRAY_MAX_WIDTH-1:0] gray;
		gray = bin ^ (bin >> 1);
		return gray;
	endfunction

endpackage

//--- verilog/ptr_sync.sv
`timescale 1ns/1ps

module ptr_sync
	import fifo_pkg::*;
#(
	parameter int PTR_WIDTH = 4
) (
	input  logic                 clk,           // destination clock
	input  logic                 reset,
	input  logic [PTR_WIDTH-1:0] ptr_gray,      // from the other domain
	output logic [PTR_WIDTH-1:0] ptr_gray_sync
);

	logic [PTR_WIDTH-1:0] stage_q [SYNC_STAGES];

	// one bit moves per step so a late sample is either the old or the new pointer
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= ptr_gray; // metastable stage
			for (int i = 1; i < SYNC_STAGES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign ptr_gray_sync = stage_q[SYNC_STAGES-1];

endmodule

//--- verilog/fifo_mem.sv
`timescale 1ns/1ps

module fifo_mem #(
	parameter int DATA_WIDTH = 4,
	parameter int DEPTH = 4,
	localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
	input  logic                  clk,
	input  logic                  wr_accept,
	input  logic [ADDR_WIDTH-1:0] wr_addr,
	input  logic [DATA_WIDTH-1:0] wr_data,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output logic [DATA_WIDTH-1:0] rd_data
);

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	// write port lives in the write clock domain
	always_ff @(posedge clk) begin
		if (wr_accept) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// fall-through read
	// the word at the read pointer is visible with no read clock edge
	assign rd_data = mem[rd_addr];

endmodule

//--- verilog/fifo_wr_side.sv
`timescale 1ns/1ps

module fifo_wr_side
	import fifo_pkg::*;
#(
	parameter int PTR_WIDTH = 4
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wr_en,
	input  logic [PTR_WIDTH-1:0] rd_ptr_gray_sync, // already in clk domain
	output logic [PTR_WIDTH-1:0] wr_ptr,
	output logic [PTR_WIDTH-1:0] wr_ptr_gray,
	output logic                 wr_accept,        // memory write strobe
	output logic                 full
);

	logic [PTR_WIDTH-1:0]      wr_ptr_next;
	logic [GRAY_MAX_WIDTH-1:0] wr_gray_next;

	assign wr_accept = wr_en & ~full;

	assign wr_ptr_next = wr_ptr + PTR_WIDTH'(1);
	assign wr_gray_next = bin_to_gray(GRAY_MAX_WIDTH'(wr_ptr_next));

	// gray copy is registered so the crossing never sees a glitch
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			wr_ptr_gray <= '0;
		end else if (wr_accept) begin
			wr_ptr <= wr_ptr_next;
			wr_ptr_gray <= wr_gray_next[PTR_WIDTH-1:0];
		end
	end

	// full when write is one lap ahead of read
	// in Gray code the top two bits are flipped and the rest are equal
	generate
		if (PTR_WIDTH > 2) begin : g_full_wide
			assign full =
				(rd_ptr_gray_sync[PTR_WIDTH-1 -: 2] == ~wr_ptr_gray[PTR_WIDTH-1 -: 2]) &&
				(rd_ptr_gray_sync[PTR_WIDTH-3:0] == wr_ptr_gray[PTR_WIDTH-3:0]);
		end else begin : g_full_narrow
			assign full = (rd_ptr_gray_sync == ~wr_ptr_gray); // depth of two
		end
	endgenerate

endmodule

//--- verilog/fifo_rd_side.sv
`timescale 1ns/1ps

module fifo_rd_side
	import fifo_pkg::*;
#(
	parameter int PTR_WIDTH = 4
) (
	input  logic                 rd_clk,
	input  logic                 reset,
	input  logic                 rd_en,
	input  logic [PTR_WIDTH-1:0] wr_ptr_gray_sync, // already in rd_clk domain
	output logic [PTR_WIDTH-1:0] rd_ptr,
	output logic [PTR_WIDTH-1:0] rd_ptr_gray,
	output logic                 empty
);

	logic                      rd_accept;
	logic [PTR_WIDTH-1:0]      rd_ptr_next;
	logic [GRAY_MAX_WIDTH-1:0] rd_gray_next;

	assign rd_accept = rd_en & ~empty; // refused while empty

	assign rd_ptr_next = rd_ptr + PTR_WIDTH'(1);
	assign rd_gray_next = bin_to_gray(GRAY_MAX_WIDTH'(rd_ptr_next));

	always_ff @(posedge rd_clk or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			rd_ptr_gray <= '0;
		end else if (rd_accept) begin
			rd_ptr <= rd_ptr_next;
			rd_ptr_gray <= rd_gray_next[PTR_WIDTH-1:0];
		end
	end

	// stale write pointer only ever makes this pessimistic
	assign empty = (wr_ptr_gray_sync == rd_ptr_gray);

endmodule

//--- verilog/async_fifo.sv
`timescale 1ns/1ps

module async_fifo
	import fifo_pkg::*;
#(
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
	parameter int DEPTH = DEFAULT_DEPTH
) (
	input  logic                  clk,     // write clock
	input  logic                  rd_clk,
	input  logic                  reset,   // both domains

	input  logic                  wr_en,
	input  logic [DATA_WIDTH-1:0] wr_data,
	output logic                  full,

	input  logic                  rd_en,
	output logic [DATA_WIDTH-1:0] rd_data,
	output logic                  empty
);

	// one extra bit tells a full lap from empty
	localparam int PTR_WIDTH = $clog2(DEPTH) + 1;
	localparam int ADDR_WIDTH = PTR_WIDTH - 1;

	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] wr_ptr_gray;
	logic [PTR_WIDTH-1:0] wr_ptr_gray_sync; // rd_clk domain
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr_gray;
	logic [PTR_WIDTH-1:0] rd_ptr_gray_sync; // clk domain
	logic                 wr_accept;

	fifo_mem #(
		.DATA_WIDTH(DATA_WIDTH),
		.DEPTH(DEPTH)
	) mem (
		.clk(clk),
		.wr_accept(wr_accept),
		.wr_addr(wr_ptr[ADDR_WIDTH-1:0]),
		.wr_data(wr_data),
		.rd_addr(rd_ptr[ADDR_WIDTH-1:0]),
		.rd_data(rd_data)
	);

	fifo_wr_side #(
		.PTR_WIDTH(PTR_WIDTH)
	) wr_side (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.rd_ptr_gray_sync(rd_ptr_gray_sync),
		.wr_ptr(wr_ptr),
		.wr_ptr_gray(wr_ptr_gray),
		.wr_accept(wr_accept),
		.full(full)
	);

	fifo_rd_side #(
		.PTR_WIDTH(PTR_WIDTH)
	) rd_side (
		.rd_clk(rd_clk),
		.reset(reset),
		.rd_en(rd_en),
		.wr_ptr_gray_sync(wr_ptr_gray_sync),
		.rd_ptr(rd_ptr),
		.rd_ptr_gray(rd_ptr_gray),
		.empty(empty)
	);

	// write pointer into the read domain
	ptr_sync #(
		.PTR_WIDTH(PTR_WIDTH)
	) wr_to_rd (
		.clk(rd_clk),
		.reset(reset),
		.ptr_gray(wr_ptr_gray),
		.ptr_gray_sync(wr_ptr_gray_sync)
	);

	// read pointer into the write domain
	ptr_sync #(
		.PTR_WIDTH(PTR_WIDTH)
	) rd_to_wr (
		.clk(clk),
		.reset(reset),
		.ptr_gray(rd_ptr_gray),
		.ptr_gray_sync(rd_ptr_gray_sync)
	);

endmodule

//--- sim/async_fifo_checker.sv
`timescale 1ns/1ps

module async_fifo_checker #(
	parameter int PTR_WIDTH = 4
) (
	input logic                 clk,
	input logic                 rd_clk,
	input logic                 reset,
	input logic                 wr_en,
	input logic                 rd_en,
	input logic                 full,
	input logic                 empty,
	input logic [PTR_WIDTH-1:0] wr_ptr,
	input logic [PTR_WIDTH-1:0] rd_ptr,
	input logic [PTR_WIDTH-1:0] wr_ptr_gray,
	input logic [PTR_WIDTH-1:0] rd_ptr_gray
);

	int fails_clk = 0;    // write domain
	int fails_rd_clk = 0; // read domain

	reset_flags: assert property (@(posedge clk) reset |-> (!full && empty))
		else begin
			$error("flags not in reset state while reset is active");
			fails_clk++;
		end

	// refused write holds the pointer
	write_refused: assert property (@(posedge clk) disable iff (reset)
		$past(wr_en && full) |-> $stable(wr_ptr))
		else begin
			$error("wr_ptr moved on a write while full");
			fails_clk++;
		end

	read_refused: assert property (@(posedge rd_clk) disable iff (reset)
		$past(rd_en && empty) |-> $stable(rd_ptr))
		else begin
			$error("rd_ptr moved on a read while empty");
			fails_rd_clk++;
		end

	wr_gray_step: assert property (@(posedge clk) disable iff (reset)
		$countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1)
		else begin
			$error("wr_ptr_gray changed more than one bit");
			fails_clk++;
		end

	rd_gray_step: assert property (@(posedge rd_clk) disable iff (reset)
		$countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1)
		else begin
			$error("rd_ptr_gray changed more than one bit");
			fails_rd_clk++;
		end

endmodule

bind async_fifo async_fifo_checker #(
	.PTR_WIDTH(PTR_WIDTH)
) fifo_chk (
	.clk(clk),
	.rd_clk(rd_clk),
	.reset(reset),
	.wr_en(wr_en),
	.rd_en(rd_en),
	.full(full),
	.empty(empty),
	.wr_ptr(wr_ptr),
	.rd_ptr(rd_ptr),
	.wr_ptr_gray(wr_ptr_gray),
	.rd_ptr_gray(rd_ptr_gray)
);

//--- sim/async_fifo_tb.sv
`timescale 1ns/1ps

module async_fifo_tb;

	localparam int DATA_WIDTH = 8;
	localparam int DEPTH = 8;
	localparam int WAIT_LIMIT = 20; // cycles of the waiting clock
	localparam int TRAFFIC_CYCLES = 400;

	logic                  clk;
	logic                  rd_clk;
	logic                  reset;
	logic                  wr_en;
	logic [DATA_WIDTH-1:0] wr_data;
	logic                  full;
	logic                  rd_en;
	logic [DATA_WIDTH-1:0] rd_data;
	logic                  empty;

	logic [DATA_WIDTH-1:0] model_q [$]; // accepted and not yet read
	int errors;
	int tests_run;
	int tests_failed;
	int checker_fails;

	async_fifo #(
		.DATA_WIDTH(DATA_WIDTH),
		.DEPTH(DEPTH)
	) UUT (
		.clk(clk),
		.rd_clk(rd_clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.full(full),
		.rd_en(rd_en),
		.rd_data(rd_data),
		.empty(empty)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rd_clk = 1'b0;
		forever #28 rd_clk = ~rd_clk; // unrelated to clk
	end

	task automatic check_level(input string name, input logic got, input logic expected);
		assert (got === expected) else begin
			$display("Error: %s is %h, expected %h", name, got, expected);
			errors++;
		end
	endtask

	// drive on the rising edge and decide at the falling edge while flags are stable
	task automatic write_slot(input logic en, input logic [DATA_WIDTH-1:0] data,
			output logic accepted);
		@(posedge clk);
		wr_en <= en;
		wr_data <= data;
		@(negedge clk);
		accepted = en && !full;
		if (accepted) begin
			model_q.push_back(data);
		end
	endtask

	task automatic write_idle();
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic read_slot(input logic en, output logic accepted);
		logic [DATA_WIDTH-1:0] expected;
		@(posedge rd_clk);
		rd_en <= en;
		@(negedge rd_clk);
		accepted = en && !empty;
		if (accepted && model_q.size() == 0) begin
			$display("Read accepted while no word was expected");
			errors++;
		end else if (accepted) begin
			expected = model_q.pop_front();
			assert (rd_data === expected) else begin
				$display("Error: rd_data is %h, expected %h", rd_data, expected);
				errors++;
			end
		end
	endtask

	task automatic read_idle();
		@(posedge rd_clk);
		rd_en <= 1'b0;
	endtask

	task automatic wait_empty(input logic level);
		int n;
		n = 0;
		while (empty !== level && n < WAIT_LIMIT) begin
			@(negedge rd_clk);
			n++;
		end
		if (empty !== level) begin
			$display("Timeout: empty did not reach %0d within %0d read clock cycles",
				level, WAIT_LIMIT);
			errors++;
		end
	endtask

	// pointer crossings take up to three edges each way
	task automatic settle_clocks();
		repeat (4) @(posedge clk);
		repeat (4) @(posedge rd_clk);
	endtask

	task automatic fill_to_full();
		logic acc;
		for (int i = 0; i < DEPTH; i++) begin
			write_slot(1'b1, DATA_WIDTH'($urandom()), acc);
			if (!acc) begin
				$display("Write %0d was refused before the FIFO was full", i);
				errors++;
			end
		end
		write_slot(1'b1, DATA_WIDTH'($urandom()), acc); // must bounce
		check_level("full", full, 1'b1);
		write_idle();
	endtask

	task automatic drain_all();
		logic acc;
		int n;
		n = 0;
		while (model_q.size() > 0 && n < DEPTH * WAIT_LIMIT) begin
			read_slot(1'b1, acc);
			n++;
		end
		read_idle();
		if (model_q.size() > 0) begin
			$display("Timeout: %0d words were never read back", model_q.size());
			errors++;
		end
		@(negedge rd_clk);
		check_level("empty", empty, 1'b1);
	endtask

	task automatic report_test(input string name, input int errors_at_start);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - errors_at_start);
		end
	endtask

	task automatic reset_state();
		int start;
		start = errors;
		@(negedge clk);
		check_level("full", full, 1'b0);
		check_level("empty", empty, 1'b1);
		@(posedge clk);
		reset <= 1'b0; // held over two rising edges
		@(negedge clk);
		check_level("full", full, 1'b0);
		check_level("empty", empty, 1'b1);
		report_test("reset state", start);
	endtask

	task automatic fill_then_drain();
		int start;
		start = errors;
		fill_to_full();
		drain_all();
		report_test("fill to full", start);
	endtask

	task automatic single_word_round_trip();
		logic acc;
		logic [DATA_WIDTH-1:0] word;
		int start;
		start = errors;
		settle_clocks();
		word = DATA_WIDTH'($urandom());
		write_slot(1'b1, word, acc);
		if (!acc) begin
			$display("Single write was refused");
			errors++;
		end
		write_idle();
		wait_empty(1'b0);
		assert (rd_data === word) else begin
			$display("Error: rd_data is %h, expected %h", rd_data, word);
			errors++;
		end
		read_slot(1'b1, acc);
		if (!acc) begin
			$display("Read was refused after empty fell");
			errors++;
		end
		read_idle();
		@(negedge rd_clk);
		check_level("empty", empty, 1'b1);
		report_test("single word", start);
	endtask

	task automatic refuse_overflow_underflow();
		logic acc;
		int start;
		start = errors;
		read_slot(1'b1, acc); // nothing stored
		if (acc) begin
			$display("Read was accepted while the FIFO was empty");
			errors++;
		end
		read_idle();
		settle_clocks();
		fill_to_full();
		drain_all();
		report_test("overflow and underflow", start);
	endtask

	task automatic run_random_traffic();
		int start;
		start = errors;
		fork
			begin
				logic wr_acc;
				repeat (TRAFFIC_CYCLES) begin
					write_slot(1'($urandom_range(0, 1)), DATA_WIDTH'($urandom()), wr_acc);
				end
				write_idle();
			end
			begin
				logic rd_acc;
				repeat (TRAFFIC_CYCLES) begin
					read_slot(1'($urandom_range(0, 1)), rd_acc);
				end
				read_idle();
			end
		join
		drain_all();
		report_test("random traffic", start);
	endtask

	initial begin
		void'($urandom(32'he493_6aaa));
		reset = 1'b1;
		wr_en = 1'b0;
		wr_data = '0;
		rd_en = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		@(posedge clk);
		reset_state();
		fill_then_drain();
		single_word_round_trip();
		refuse_overflow_underflow();
		run_random_traffic();
		checker_fails = UUT.fifo_chk.fails_clk + UUT.fifo_chk.fails_rd_clk;
		$display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, checker_fails);
		if (errors == 0 && tests_failed == 0 && checker_fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		#200_000;
		$display("Simulation ran past its time limit");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- flist.f
verilog/fifo_pkg.sv
verilog/ptr_sync.sv
verilog/fifo_mem.sv
verilog/fifo_wr_side.sv
verilog/fifo_rd_side.sv
verilog/async_fifo.sv
sim/async_fifo_checker.sv
sim/async_fifo_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the async FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert --top-module async_fifo_tb -f flist.f -o async_fifo_sim \
	> build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/async_fifo_sim +verilator+error+limit+100 > sim.log 2>&1 \
	|| echo "simulator returned a failing status"

cat sim.log

grep -q "^=== PASS ===$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
